/* project.f */
+incdir+verif
hdl/rp_pkg.sv
hdl/adc_capture.sv
hdl/analog_channel.sv
hdl/dac_interleave.sv
hdl/house_regs.sv
hdl/rp_top.sv
verif/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_top \
  || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_top 2>&1)
echo "$sim_out"
grep -q "TESTS PASSED" <<< "$sim_out" && exit 0 || exit 1

/* verif/tb_tasks.svh */
//////////////////////////////
// Testbench helpers
// Bus access, DAC frame capture and reference conversions
//////////////////////////////

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Negative slope so code 0 is +8191 and code 16383 is -8192
  function automatic int adc_to_sample(input adc_raw_t raw);
    return 8191 - int'(raw >> 2);  // Two LSBs unused
  endfunction

  // Clamp to the 14-bit signed range
  function automatic int clamp_sample(input int v);
    if (v > 8191)
      return 8191;
    if (v < -8192)
      return -8192;
    return v;
  endfunction

  // Same negative-slope mapping on the way out
  function automatic dac_word_t sample_to_dac(input int s);
    return dac_word_t'(8191 - s);
  endfunction

  //////////////////////////////
  // Reset and bus
  //////////////////////////////

  // Called on a falling edge
  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (4)
    begin
      @(negedge adc_clk);
      assert (!dac_wrt) else value_error("DAC strobe high during reset");
    end
    arst_n = 1'b1;  // Released on a falling edge
  endtask

  // One request with the ack expected on the next cycle only
  task automatic bus_access(input logic [7:0] addr, input logic [31:0] wdata,
                            input logic wr, output logic [31:0] rdata, output logic err);
    @(negedge adc_clk);
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = wr;
    sys_req.ren   = !wr;
    assert (!sys_rsp.ack) else value_error("ack before the request");
    @(negedge adc_clk);
    sys_req = '0;
    assert (sys_rsp.ack) else value_error($sformatf("no ack for address %h", addr));
    rdata = sys_rsp.rdata;
    err   = sys_rsp.err;
    @(negedge adc_clk);
    assert (!sys_rsp.ack) else value_error("ack longer than one cycle");
  endtask

  //////////////////////////////
  // DAC frames
  //////////////////////////////

  // Words land in frame[] by select and an idle cycle must follow
  task automatic wait_frame();
    int wait_cyc;
    wait_cyc = 0;
    @(negedge adc_clk);
    while (!(dac_wrt && dac_sel == '0))
    begin
      if (wait_cyc == 100)
        run_aborted("No DAC frame started within 100 cycles");
      wait_cyc++;
      @(negedge adc_clk);
    end
    for (int k = 0; k < N_CH; k++)
    begin
      assert (dac_wrt && int'(dac_sel) == k)
        else value_error($sformatf("DAC select %0d, expected %0d", dac_sel, k));
      frame[k] = dac_dat;
      @(negedge adc_clk);
    end
    assert (!dac_wrt) else value_error("no idle cycle after a DAC frame");
  endtask

  task automatic skip_frames(input int n);
    repeat (n)
      wait_frame();
  endtask

  // Flush the pipeline and compare n frames with expect_smp[]
  task automatic check_frames(input int n);
    skip_frames(4);
    repeat (n)
    begin
      wait_frame();
      for (int k = 0; k < N_CH; k++)
        assert (frame[k] == sample_to_dac(expect_smp[k]))
          else value_error($sformatf("ch %0d DAC word %h, expected %h", k, frame[k],
                                     sample_to_dac(expect_smp[k])));
    end
  endtask

`endif

/* verif/tb_top.sv */
//////////////////////////////
// Testbench for the analog datapath top
// Clock, reset, watchdog and directed tests
//////////////////////////////

`timescale 1ns/1ps

module tb_top;

  import rp_pkg::*;

  localparam int          N_CH     = 2;
  localparam logic [31:0] BOARD_ID = 32'h5250_0001;
  localparam int          CLK_NS   = 20;
  localparam int          N_TESTS  = 6;

  logic                    adc_clk;
  logic                    arst_n;
  adc_raw_t  [N_CH-1:0]    adc_dat;
  sample_t   [N_CH-1:0]    asg_dat;
  sample_t   [N_CH-1:0]    pid_dat;
  sys_req_t                sys_req;
  sys_rsp_t                sys_rsp;
  dac_word_t               dac_dat;
  logic [$clog2(N_CH)-1:0] dac_sel;
  logic                    dac_wrt;
  dac_word_t               frame[N_CH];       // Last captured DAC frame
  int                      expect_smp[N_CH];  // Expected channel samples

  initial adc_clk = 1'b0;
  always #(CLK_NS / 2) adc_clk = ~adc_clk;

  rp_top #(
    .N_CH     (N_CH    ),
    .BOARD_ID (BOARD_ID)
  ) i_dut (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n ),
    .adc_dat_i (adc_dat),
    .asg_dat_i (asg_dat),
    .pid_dat_i (pid_dat),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .dac_dat_o (dac_dat),
    .dac_sel_o (dac_sel),
    .dac_wrt_o (dac_wrt)
  );

  //////////////////////////////
  // Failure exits
  //////////////////////////////

  task automatic value_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic run_aborted(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Run aborted");
  endtask

  `include "tb_tasks.svh"

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_regs();
    logic [31:0] rd;
    logic        er;
    bus_access(REG_ID, 32'd0, 1'b0, rd, er);
    assert (rd == BOARD_ID && !er) else value_error($sformatf("ID read %h", rd));
    bus_access(REG_CFG, 32'd1, 1'b1, rd, er);
    bus_access(REG_CFG, 32'd0, 1'b0, rd, er);
    assert (rd[0] && !er) else value_error("loopback bit did not read back");
    bus_access(REG_CFG, 32'd0, 1'b1, rd, er);  // Loopback off again
    bus_access(8'h0C, 32'd0, 1'b0, rd, er);
    assert (er) else value_error("no err on unmapped address");
  endtask

  // ADC only with generator and feedback quiet
  task automatic test_conversion();
    repeat (3)
    begin
      @(negedge adc_clk);
      for (int k = 0; k < N_CH; k++)
      begin
        adc_dat[k]    = adc_raw_t'($urandom);
        asg_dat[k]    = '0;
        pid_dat[k]    = '0;
        expect_smp[k] = adc_to_sample(adc_dat[k]);
      end
      check_frames(6);
    end
  endtask

  task automatic test_saturation();
    repeat (4)
    begin
      @(negedge adc_clk);
      for (int k = 0; k < N_CH; k++)
      begin
        adc_dat[k]    = adc_raw_t'($urandom);
        asg_dat[k]    = sample_t'($urandom);
        pid_dat[k]    = sample_t'($urandom);
        expect_smp[k] = clamp_sample(adc_to_sample(adc_dat[k]) + int'(asg_dat[k])
                                     + int'(pid_dat[k]));
      end
      check_frames(4);
    end
    @(negedge adc_clk);
    adc_dat[0] = 16'h0000;  // +8191 on all three inputs
    asg_dat[0] = sample_t'(8191);
    pid_dat[0] = sample_t'(8191);
    adc_dat[1] = 16'hFFFF;  // -8192 on all three inputs
    asg_dat[1] = sample_t'(-8192);
    pid_dat[1] = sample_t'(-8192);
    expect_smp[0] = 8191;
    expect_smp[1] = -8192;
    check_frames(4);
  endtask

  task automatic test_interleave();
    int cyc;
    apply_reset();
    cyc = 0;
    while (!dac_wrt)
    begin
      if (cyc == 100)
        run_aborted("No DAC strobe after reset");
      cyc++;
      @(negedge adc_clk);
    end
    assert (dac_sel == '0) else value_error("first DAC word after reset not channel 0");
    skip_frames(10);  // Select order checked per frame
  endtask

  // Each frame adds the generator to the channel's own last output
  task automatic test_loopback();
    logic [31:0] rd;
    logic        er;
    int          step[N_CH];
    bit          started[N_CH];
    @(negedge adc_clk);
    for (int k = 0; k < N_CH; k++)
    begin
      adc_dat[k]    = 16'h7FFC;  // Converts to 0
      asg_dat[k]    = '0;
      pid_dat[k]    = '0;
      expect_smp[k] = 0;
      started[k]    = 1'b0;
    end
    skip_frames(4);
    bus_access(REG_CFG, 32'd1, 1'b1, rd, er);
    step[0] = 1000;
    step[1] = -3000;
    @(negedge adc_clk);
    asg_dat[0] = sample_t'(step[0]);
    asg_dat[1] = sample_t'(step[1]);
    repeat (14)
    begin
      wait_frame();
      for (int k = 0; k < N_CH; k++)
      begin
        if (started[k] || frame[k] != sample_to_dac(0))
        begin
          started[k]    = 1'b1;
          expect_smp[k] = clamp_sample(expect_smp[k] + step[k]);
          assert (frame[k] == sample_to_dac(expect_smp[k]))
            else value_error($sformatf("loopback ch %0d word %h", k, frame[k]));
        end
      end
    end
    assert (expect_smp[0] == 8191 && expect_smp[1] == -8192)
      else value_error("loopback series did not reach the rails");
    bus_access(REG_CFG, 32'd0, 1'b1, rd, er);
  endtask

  task automatic test_overrun();
    logic [31:0] first;
    logic [31:0] second;
    logic        er;
    bus_access(REG_OVR, 32'd0, 1'b0, first, er);
    skip_frames(20);
    bus_access(REG_OVR, 32'd0, 1'b0, second, er);
    assert (first > 0 && second >= first && !er)
      else value_error($sformatf("overrun count %0d then %0d", first, second));
  endtask

  //////////////////////////////
  // Watchdog and sequence
  //////////////////////////////

  initial
  begin
    #(N_TESTS * 2000 * CLK_NS);
    run_aborted("Timeout: the tests did not finish in time");
  end

  initial
  begin
    void'($urandom(80));
    arst_n  = 1'b0;
    adc_dat = '0;
    asg_dat = '0;
    pid_dat = '0;
    sys_req = '0;
    apply_reset();
    test_regs();
    test_conversion();
    test_saturation();
    test_interleave();
    test_loopback();
    test_overrun();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* hdl/rp_top.sv */
//////////////////////////////
// Analog datapath top
// ADC capture, per-channel sum, DAC interleave
// and housekeeping registers
//////////////////////////////

`timescale 1ns/1ps

module rp_top #(
  parameter int          N_CH     = 2,
  parameter logic [31:0] BOARD_ID = 32'h5250_0001
) (
  input  logic                              adc_clk,
  input  logic                              arst_n_i,
  // ADC and sample inputs
  input  rp_pkg::adc_raw_t [N_CH-1:0]       adc_dat_i,
  input  rp_pkg::sample_t  [N_CH-1:0]       asg_dat_i,
  input  rp_pkg::sample_t  [N_CH-1:0]       pid_dat_i,
  // System bus
  input  rp_pkg::sys_req_t                  sys_req_i,
  output rp_pkg::sys_rsp_t                  sys_rsp_o,
  // Shared DAC bus
  output rp_pkg::dac_word_t                 dac_dat_o,
  output logic             [$clog2(N_CH)-1:0] dac_sel_o,
  output logic                              dac_wrt_o
);

  import rp_pkg::*;

  sample_t [N_CH-1:0] adc_smp;       // Converted ADC samples
  logic               adc_valid;
  logic               adc_ready;     // AND of all channels
  logic [N_CH-1:0]    ch_adc_ready;  // Per-channel input ready
  sample_t [N_CH-1:0] ch_smp;        // Channel outputs
  logic [N_CH-1:0]    ch_valid;
  logic               ch_ready;      // Shared, from interleaver
  logic [15:0]        ovr_cnt;
  logic               loop_en;

  //////////////////////////////
  // ADC capture
  //////////////////////////////

  adc_capture #(
    .N_CH (N_CH)
  ) i_adc (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .adc_dat_i (adc_dat_i),
    .smp_o     (adc_smp  ),
    .valid_o   (adc_valid),
    .ready_i   (adc_ready),
    .ovr_cnt_o (ovr_cnt  )
  );

  assign adc_ready = &ch_adc_ready;  // Channels step in lockstep

  //////////////////////////////
  // Channel array
  //////////////////////////////

  for (genvar k = 0; k < N_CH; k++)
  begin : g_ch
    analog_channel i_ch (
      .adc_clk     (adc_clk        ),
      .arst_n_i    (arst_n_i       ),
      .adc_smp_i   (adc_smp[k]     ),
      .adc_valid_i (adc_valid      ),
      .adc_ready_o (ch_adc_ready[k]),
      .asg_i       (asg_dat_i[k]   ),
      .pid_i       (pid_dat_i[k]   ),
      .loop_en_i   (loop_en        ),
      .dac_smp_o   (ch_smp[k]      ),
      .dac_valid_o (ch_valid[k]    ),
      .dac_ready_i (ch_ready       )
    );
  end

  //////////////////////////////
  // DAC interleaver
  //////////////////////////////

  dac_interleave #(
    .N_CH (N_CH)
  ) i_dac (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .smp_i     (ch_smp   ),
    .valid_i   (ch_valid ),
    .ready_o   (ch_ready ),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_wrt_o (dac_wrt_o)
  );

  //////////////////////////////
  // Housekeeping
  //////////////////////////////

  house_regs #(
    .BOARD_ID (BOARD_ID),
    .N_CH     (N_CH    )
  ) i_regs (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .req_i     (sys_req_i),
    .rsp_o     (sys_rsp_o),
    .ovr_cnt_i (ovr_cnt  ),
    .loop_en_o (loop_en  )
  );

endmodule

/* hdl/house_regs.sv */
//////////////////////////////
// Housekeeping registers
// Board ID, loopback enable and ADC overrun count
// on the one-cycle system bus
//////////////////////////////

`timescale 1ns/1ps

module house_regs #(
  parameter logic [31:0] BOARD_ID = 32'h0000_0000,
  parameter int          N_CH     = 2
) (
  input  logic             adc_clk,
  input  logic             arst_n_i,
  // System bus
  input  rp_pkg::sys_req_t req_i,
  output rp_pkg::sys_rsp_t rsp_o,
  // Status and config
  input  logic [15:0]      ovr_cnt_i,
  output logic             loop_en_o
);

  import rp_pkg::*;

  logic        req;      // Any access this cycle
  logic        hit;      // Address is mapped
  logic [31:0] rd_mux;   // Read data before register

  assign req = req_i.wen || req_i.ren;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_mux = '0;
    case (reg_addr_e'(req_i.addr))
      REG_ID:  rd_mux = BOARD_ID;
      REG_CFG: rd_mux = {31'd0, loop_en_o};
      REG_OVR: rd_mux = {16'd0, ovr_cnt_i};  // Zero extended
      default: hit    = 1'b0;
    endcase
  end

  // Only CFG is writable and other writes just ack
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      loop_en_o <= 1'b0;
    else if (req_i.wen && (req_i.addr == REG_CFG))
      loop_en_o <= req_i.wdata[0];
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  // Ack and err exactly one cycle after the request
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsp_o <= '0;
    end
    else
    begin
      rsp_o.ack   <= req;
      rsp_o.err   <= req && !hit;
      rsp_o.rdata <= req_i.ren ? rd_mux : 32'd0;
    end
  end

  // No ack without a request on the cycle before
  a_ack_timing: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    rsp_o.ack |-> $past(req));

endmodule

/* hdl/dac_interleave.sv */
//////////////////////////////
// DAC interleaver
// Takes one frame from all channels, then sends one
// offset-binary word per cycle on the shared DAC bus
//////////////////////////////

`timescale 1ns/1ps

module dac_interleave #(
  parameter int N_CH = 2
) (
  input  logic                           adc_clk,
  input  logic                           arst_n_i,
  // Channel samples
  input  rp_pkg::sample_t [N_CH-1:0]     smp_i,
  input  logic            [N_CH-1:0]     valid_i,
  output logic                           ready_o,
  // Shared DAC bus
  output rp_pkg::dac_word_t              dac_dat_o,
  output logic            [$clog2(N_CH)-1:0] dac_sel_o,
  output logic                           dac_wrt_o
);

  import rp_pkg::*;

  localparam int SEL_W = $clog2(N_CH);
  localparam logic [SEL_W-1:0] LAST_CH = SEL_W'(N_CH - 1);

  mux_state_e         state;   // FSM state
  logic [SEL_W-1:0]   cnt;     // Channel being sent
  sample_t [N_CH-1:0] lat_q;   // Latched frame
  sample_t            cur;     // Current channel sample
  logic               xfer;    // Frame taken this cycle

  //////////////////////////////
  // Frame handshake
  //////////////////////////////

  // All channels move together and only from idle
  assign ready_o = (state == MUX_IDLE) && (&valid_i);
  assign xfer    = ready_o;  // ready implies all valid

  // Whole frame latched on a transfer
  always_ff @(posedge adc_clk)
  begin
    if (xfer)
      lat_q <= smp_i;
  end

  //////////////////////////////
  // Send FSM
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state <= MUX_IDLE;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        MUX_IDLE:
        begin
          cnt <= '0;
          if (xfer)
            state <= MUX_SEND;
        end
        MUX_SEND:
        begin
          if (cnt == LAST_CH)
          begin
            state <= MUX_IDLE;  // One idle cycle minimum
            cnt   <= '0;
          end
          else
          begin
            cnt <= cnt + 1'b1;
          end
        end
        default:
        begin
          state <= MUX_IDLE;
        end
      endcase
    end
  end

  // Back to negative-slope offset binary
  assign cur       = lat_q[cnt];
  assign dac_dat_o = {cur[13], ~cur[12:0]};
  assign dac_sel_o = cnt;
  assign dac_wrt_o = (state == MUX_SEND);  // One strobe per channel word

  // Select never points past the last channel on a write
  a_sel_range: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    dac_wrt_o |-> (int'(dac_sel_o) < N_CH));

endmodule

/* hdl/analog_channel.sv */
//////////////////////////////
// Analog channel
// Loopback select, generator plus feedback plus input sum,
// saturation to 14 bits and output register
//////////////////////////////

`timescale 1ns/1ps

module analog_channel (
  input  logic            adc_clk,
  input  logic            arst_n_i,
  // From ADC capture
  input  rp_pkg::sample_t adc_smp_i,
  input  logic            adc_valid_i,
  output logic            adc_ready_o,
  // Generator and feedback samples
  input  rp_pkg::sample_t asg_i,
  input  rp_pkg::sample_t pid_i,
  // Configuration
  input  logic            loop_en_i,
  // Towards DAC interleaver
  output rp_pkg::sample_t dac_smp_o,
  output logic            dac_valid_o,
  input  logic            dac_ready_i
);

  import rp_pkg::*;

  sample_t            in_smp;   // ADC or loopback sample
  sum_t               gen_sum;  // Generator plus feedback
  logic signed [15:0] tot;      // Full sum, cannot wrap
  logic               in_rng;   // Sum fits in 14 bits
  sample_t            sat_smp;  // Clamped result
  logic               xfer;     // Input transfer this cycle

  //////////////////////////////
  // Input select and sum
  //////////////////////////////

  // Loopback takes our own last output instead of the ADC
  assign in_smp  = loop_en_i ? dac_smp_o : adc_smp_i;

  assign gen_sum = asg_i + pid_i;   // 15 bits, no overflow
  assign tot     = gen_sum + in_smp;  // Sign extended to 16

  // Top three bits equal means the value fits in 14 bits
  assign in_rng  = (tot[15:13] == 3'b000) || (tot[15:13] == 3'b111);

  // Clamp to +8191 or -8192 by sign
  assign sat_smp = in_rng ? tot[13:0] : {tot[15], {13{~tot[15]}}};

  //////////////////////////////
  // Output slot
  //////////////////////////////

  // Accept when empty or being drained this cycle
  assign adc_ready_o = !dac_valid_o || dac_ready_i;
  assign xfer        = adc_valid_i && adc_ready_o;

  // Output register doubles as the loopback register
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_smp_o   <= '0;
      dac_valid_o <= 1'b0;
    end
    else if (xfer)
    begin
      dac_smp_o   <= sat_smp;
      dac_valid_o <= 1'b1;
    end
    else if (dac_ready_i)
    begin
      dac_valid_o <= 1'b0;  // Taken, nothing new behind it
    end
  end

  // Output frozen until the interleaver takes it
  a_out_hold: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    dac_valid_o && !dac_ready_i |=> dac_valid_o && $stable(dac_smp_o));

endmodule

/* hdl/adc_capture.sv */
//////////////////////////////
// ADC capture
// Registers raw ADC words, converts to two's complement
// and holds them under back-pressure, counting lost samples
//////////////////////////////

`timescale 1ns/1ps

module adc_capture #(
  parameter int N_CH = 2
) (
  input  logic                             adc_clk,
  input  logic                             arst_n_i,
  // Raw ADC pins
  input  rp_pkg::adc_raw_t [N_CH-1:0]      adc_dat_i,
  // Converted samples towards the channels
  output rp_pkg::sample_t  [N_CH-1:0]      smp_o,
  output logic                             valid_o,
  input  logic                             ready_i,
  // Lost sample count
  output logic             [15:0]          ovr_cnt_o
);

  import rp_pkg::*;

  sample_t [N_CH-1:0] cnv;       // Converted raw words
  logic               load;      // Output slot free or being taken
  logic               ovr_full;  // Counter at its top

  //////////////////////////////
  // Raw to two's complement
  //////////////////////////////

  // Drop the two LSBs, keep MSB, flip the rest (negative slope)
  always_comb
  begin
    for (int i = 0; i < N_CH; i++)
    begin
      cnv[i] = {adc_dat_i[i][15], ~adc_dat_i[i][14:2]};
    end
  end

  assign load     = !valid_o || ready_i;
  assign ovr_full = &ovr_cnt_o;

  //////////////////////////////
  // Holding register
  //////////////////////////////

  // New word goes in when the slot frees up
  always_ff @(posedge adc_clk)
  begin
    if (load)
      smp_o <= cnv;  // Only while the slot can take it
  end

  // ADC never stops so valid stays up after the first word
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_o <= 1'b0;
    else
      valid_o <= 1'b1;
  end

  // Count words dropped while the slot is stalled
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ovr_cnt_o <= '0;
    else if (!load && !ovr_full)
      ovr_cnt_o <= ovr_cnt_o + 16'd1;  // Saturates at all ones
  end

  // Held samples must not move under back-pressure
  a_smp_hold: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    valid_o && !ready_i |=> $stable(smp_o));

endmodule

/* hdl/rp_pkg.sv */
//////////////////////////////
// Shared types for the two-channel analog datapath
// Sample formats, system bus request/response and state encodings
//////////////////////////////

package rp_pkg;

  //////////////////////////////
  // Sample formats
  //////////////////////////////

  // Two's complement sample, internal datapath
  typedef logic signed [13:0] sample_t;

  // Generator plus feedback, one guard bit
  typedef logic signed [14:0] sum_t;

  // Raw ADC word, two LSBs unused on the 14-bit part
  typedef logic [15:0] adc_raw_t;

  // Negative-slope offset binary, as the DAC wants it
  typedef logic [13:0] dac_word_t;

  //////////////////////////////
  // System bus
  //////////////////////////////

  // One-cycle request, no handshake back-pressure
  typedef struct packed {
    logic [7:0]  addr;   // Byte address
    logic [31:0] wdata;  // Write data
    logic        wen;    // Write strobe
    logic        ren;    // Read strobe
  } sys_req_t;

  // Response, always one cycle after request
  typedef struct packed {
    logic [31:0] rdata;  // Read data
    logic        ack;    // Request done
    logic        err;    // Unmapped address
  } sys_rsp_t;

  // Register map of the housekeeping block
  typedef enum logic [7:0] {
    REG_ID  = 8'h00,  // Board ID, read only
    REG_CFG = 8'h04,  // Bit 0 loopback enable
    REG_OVR = 8'h08   // ADC overrun count, read only
  } reg_addr_e;

  //////////////////////////////
  // DAC interleaver FSM
  //////////////////////////////

  typedef enum logic {
    MUX_IDLE = 1'b0,  // Waiting for a full frame
    MUX_SEND = 1'b1   // Walking through the channels
  } mux_state_e;

endpackage
